// ==== compile.f ====
+incdir+bench
common/p4_proc_pkg.sv
common/pkt_stream_if.sv
p4_meta/p4_meta_encode.sv
p4_meta/p4_meta_decode.sv
pkt_filter/pkt_drop_filter.sv
pkt_filter/pkt_truncate.sv
src/p4_proc_core.sv
bench/tb_p4_proc_core.sv

// ==== Bender.yml ====
package:
  name: p4_proc_core

sources:
  - files:
      - common/p4_proc_pkg.sv
      - common/pkt_stream_if.sv
      - p4_meta/p4_meta_encode.sv
      - p4_meta/p4_meta_decode.sv
      - pkt_filter/pkt_drop_filter.sv
      - pkt_filter/pkt_truncate.sv
      - src/p4_proc_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_p4_proc_core.sv

// ==== bench/tb_checks.svh ====
task automatic report_mismatch(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    abort_run();
endtask

task automatic compare_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    end
endtask

task automatic compare_port(input string what, input port_t got, input port_t exp);
    if (got !== exp) begin
        report_mismatch($sformatf("%s is type %0d port %0d, expected type %0d port %0d",
                                  what, got.typ, got.num, exp.typ, exp.num));
    end
endtask

task automatic compare_meta(input user_metadata_t got, input user_metadata_t exp);
    if (got !== exp) begin
        report_mismatch($sformatf("p4_meta_out is %h, expected %h", got, exp));
    end
endtask

// data is only compared on the bytes that the expected keep holds.
task automatic compare_beat(input string                 what,
                            input logic [DW-1:0]         got_data,
                            input logic [DATA_BYTES-1:0] got_keep,
                            input logic                  got_last,
                            input logic [DW-1:0]         exp_data,
                            input logic [DATA_BYTES-1:0] exp_keep,
                            input logic                  exp_last);
    logic [DW-1:0] mask;
    for (int i = 0; i < DATA_BYTES; i++) begin
        mask[i*8 +: 8] = {8{exp_keep[i]}};
    end
    if (got_keep !== exp_keep || got_last !== exp_last ||
        (got_data & mask) !== (exp_data & mask)) begin
        report_mismatch($sformatf("%s beat is %h/%h/%b, expected %h/%h/%b", what,
                                  got_data, got_keep, got_last, exp_data, exp_keep, exp_last));
    end
endtask

// ==== bench/tb_p4_proc_core.sv ====
`timescale 1ns/1ps

module tb_p4_proc_core;
    import p4_proc_pkg::*;

    localparam int          DATA_BYTES  = 8;
    localparam int          DW          = DATA_BYTES * 8;
    localparam int          NUM_PKTS    = 200;
    localparam int          WATCHDOG_NS = NUM_PKTS * 6 * 4 * 8;
    localparam logic [31:0] LFSR_SEED   = 32'h1a39_ee30;

    logic                    core_clk;
    logic                    srst;
    logic [TIMESTAMP_WID-1:0] timestamp;
    logic                    in_tvalid, in_tready, in_tlast;
    logic [DW-1:0]           in_tdata;
    logic [DATA_BYTES-1:0]   in_tkeep;
    port_t                   in_tid;
    logic                    p4_tx_tvalid, p4_tx_tready, p4_tx_tlast;
    logic [DW-1:0]           p4_tx_tdata;
    logic [DATA_BYTES-1:0]   p4_tx_tkeep;
    user_metadata_t          p4_meta_out;
    logic                    p4_meta_out_valid;
    logic                    p4_rx_tvalid, p4_rx_tready, p4_rx_tlast;
    logic [DW-1:0]           p4_rx_tdata;
    logic [DATA_BYTES-1:0]   p4_rx_tkeep;
    user_metadata_t          p4_meta_in;
    logic                    p4_meta_in_valid;
    logic                    out_tvalid, out_tready, out_tlast;
    logic [DW-1:0]           out_tdata;
    logic [DATA_BYTES-1:0]   out_tkeep;
    port_t                   out_tid;
    port_t                   out_tdest;

    // beats taken by the P4 stand-in, not yet returned.
    logic [DW-1:0]           tx_data_q[$];
    logic [DATA_BYTES-1:0]   tx_keep_q[$];
    logic                    tx_last_q[$];
    user_metadata_t          tx_meta_q[$];
    // reference model output, one entry per expected beat.
    logic [DW-1:0]           exp_data_q[$];
    logic [DATA_BYTES-1:0]   exp_keep_q[$];
    logic                    exp_last_q[$];
    port_t                   exp_tid_q[$];
    port_t                   exp_dest_q[$];
    logic [31:0]             lfsr_state [0:2];
    user_metadata_t          cur_meta;
    logic                    tx_sop;
    int                      pkts_kept;
    int                      pkts_out;

    p4_proc_core #(.DATA_BYTES(DATA_BYTES)) uut (.*);

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on failure");
    endtask

    `include "tb_checks.svh"

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken, each stimulus source has its own register.
    function automatic logic [31:0] rand_bits(input int src, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state[src] = lfsr_step(lfsr_state[src]);
            v = {v[30:0], lfsr_state[src][0]};
        end
        return v;
    endfunction

    function automatic logic [DATA_BYTES-1:0] keep_for(input int bytes);
        logic [DATA_BYTES-1:0] k;
        for (int i = 0; i < DATA_BYTES; i++) begin
            k[i] = (i < bytes);
        end
        return k;
    endfunction

    initial begin
        core_clk = 1'b0;
        forever #2 core_clk = ~core_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the packets did not all arrive within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    // ------------------------------------------------------------------------
    // stimulus.
    // ------------------------------------------------------------------------
    task automatic drive_ready_and_time();
        forever begin
            @(posedge core_clk);
            #1;
            timestamp    = timestamp + 1'b1;
            p4_tx_tready = (rand_bits(2, 2) != 0);
            out_tready   = (rand_bits(2, 2) != 0);
        end
    endtask

    task automatic drive_ingress();
        int len;
        int nb;
        for (int p = 0; p < NUM_PKTS; p++) begin
            len        = int'(rand_bits(0, 6) % 41);
            nb         = (len == 0) ? 1 : (len + DATA_BYTES - 1) / DATA_BYTES;
            in_tid.typ = port_typ_t'(rand_bits(0, 3) % 5);
            in_tid.num = PORT_NUM_WID'(rand_bits(0, 1));
            for (int b = 0; b < nb; b++) begin
                if (rand_bits(0, 1) != 0) begin
                    in_tvalid = 1'b0;
                    @(posedge core_clk);
                    #1;
                end
                for (int i = 0; i < DATA_BYTES; i++) begin
                    in_tdata[i*8 +: 8] = 8'(rand_bits(0, 8));
                end
                in_tkeep  = keep_for(len - b * DATA_BYTES);
                in_tlast  = (b == nb - 1);
                in_tvalid = 1'b1;
                @(negedge core_clk);
                while (!in_tready) begin
                    @(negedge core_clk);
                end
                @(posedge core_clk);
                #1;
            end
        end
        in_tvalid = 1'b0;
    endtask

    // stands in for the P4 block and feeds the reference model.
    task automatic run_p4_standin();
        logic [DW-1:0]         data [0:7];
        logic [DATA_BYTES-1:0] keep [0:7];
        logic                  last;
        user_metadata_t        meta;
        logic [3:0]            code;
        port_t                 dest;
        int                    nb;
        int                    len;
        int                    n_out;
        for (int p = 0; p < NUM_PKTS; p++) begin
            while (tx_meta_q.size() == 0) begin
                @(posedge core_clk);
                #1;
            end
            meta = tx_meta_q.pop_front();
            nb   = 0;
            len  = 0;
            do begin
                data[nb] = tx_data_q.pop_front();
                keep[nb] = tx_keep_q.pop_front();
                last     = tx_last_q.pop_front();
                len      = len + $countones(keep[nb]);
                nb       = nb + 1;
            end while (!last);
            code                 = 4'(rand_bits(1, 4));
            meta.egress_code.raw = code;
            meta.trunc.enable    = (rand_bits(1, 1) != 0);
            meta.trunc.length    = TRUNC_LEN_WID'(1 + rand_bits(1, 6) % 48);
            n_out = len;
            if (meta.trunc.enable && meta.trunc.length < len) begin
                n_out = meta.trunc.length;
            end
            // unset destinations and empty packets never reach the output.
            if (code[3:1] < TYPE_CODE_UNSET_FIRST && len != 0) begin
                dest.typ  = port_typ_t'(code[3:1]);
                dest.num  = code[0];
                pkts_kept = pkts_kept + 1;
                for (int b = 0; b * DATA_BYTES < n_out; b++) begin
                    exp_data_q.push_back(data[b]);
                    exp_keep_q.push_back(keep_for(n_out - b * DATA_BYTES));
                    exp_last_q.push_back((b + 1) * DATA_BYTES >= n_out);
                    exp_tid_q.push_back(meta.ingress_port);
                    exp_dest_q.push_back(dest);
                end
            end
            for (int b = 0; b < nb; b++) begin
                if (rand_bits(1, 1) != 0) begin
                    p4_rx_tvalid     = 1'b0;
                    p4_meta_in_valid = 1'b0;
                    @(posedge core_clk);
                    #1;
                end
                p4_rx_tvalid     = 1'b1;
                p4_rx_tdata      = data[b];
                p4_rx_tkeep      = keep[b];
                p4_rx_tlast      = (b == nb - 1);
                p4_meta_in       = meta;
                p4_meta_in_valid = (b == 0);
                @(negedge core_clk);
                while (!p4_rx_tready) begin
                    @(negedge core_clk);
                end
                @(posedge core_clk);
                #1;
            end
            p4_rx_tvalid     = 1'b0;
            p4_meta_in_valid = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // monitors, sampled on the falling edge where everything is settled.
    // ------------------------------------------------------------------------
    task automatic check_p4_tx();
        user_metadata_t exp_meta;
        compare_flag("in_tready", in_tready, p4_tx_tready);
        compare_flag("p4_tx_tvalid", p4_tx_tvalid, in_tvalid);
        compare_flag("p4_meta_out_valid", p4_meta_out_valid, in_tvalid && tx_sop);
        if (in_tvalid && p4_tx_tready) begin
            compare_beat("p4_tx", p4_tx_tdata, p4_tx_tkeep, p4_tx_tlast,
                         in_tdata, in_tkeep, in_tlast);
            if (tx_sop) begin
                exp_meta.timestamp       = timestamp;
                exp_meta.ingress_port    = in_tid;
                exp_meta.egress_code.raw = {3'd5, in_tid.num};
                exp_meta.trunc           = '0;
                compare_meta(p4_meta_out, exp_meta);
                cur_meta = exp_meta;
            end
            tx_data_q.push_back(in_tdata);
            tx_keep_q.push_back(in_tkeep);
            tx_last_q.push_back(in_tlast);
            if (in_tlast) begin
                tx_meta_q.push_back(cur_meta);
            end
            tx_sop = in_tlast;
        end
    endtask

    task automatic check_output();
        if (out_tvalid && out_tready) begin
            if (exp_data_q.size() == 0) begin
                $display("an output beat arrived while no kept packet was outstanding");
                abort_run();
            end else begin
                compare_beat("out", out_tdata, out_tkeep, out_tlast, exp_data_q.pop_front(),
                             exp_keep_q.pop_front(), exp_last_q.pop_front());
                compare_port("out_tid", out_tid, exp_tid_q.pop_front());
                compare_port("out_tdest", out_tdest, exp_dest_q.pop_front());
                if (out_tlast) begin
                    pkts_out = pkts_out + 1;
                end
            end
        end
    endtask

    initial begin
        forever begin
            @(negedge core_clk);
            if (!srst) begin
                check_p4_tx();
                check_output();
            end
        end
    end

    initial begin
        srst             = 1'b1;
        timestamp        = '0;
        in_tvalid        = 1'b0;
        in_tdata         = '0;
        in_tkeep         = '0;
        in_tlast         = 1'b0;
        in_tid           = '0;
        p4_tx_tready     = 1'b0;
        p4_rx_tvalid     = 1'b0;
        p4_rx_tdata      = '0;
        p4_rx_tkeep      = '0;
        p4_rx_tlast      = 1'b0;
        p4_meta_in       = '0;
        p4_meta_in_valid = 1'b0;
        out_tready       = 1'b0;
        tx_sop           = 1'b1;
        pkts_kept        = 0;
        pkts_out         = 0;
        for (int k = 0; k < 3; k++) begin
            lfsr_state[k] = LFSR_SEED ^ k;
        end
        repeat (2) @(posedge core_clk);
        #1;
        srst = 1'b0;
        compare_flag("out_tvalid after reset", out_tvalid, 1'b0);
        fork
            drive_ready_and_time();
        join_none
        fork
            drive_ingress();
            run_p4_standin();
        join
        while (exp_data_q.size() != 0) begin
            @(posedge core_clk);
        end
        repeat (8) @(posedge core_clk);
        if (pkts_out != pkts_kept) begin
            $display("%0d packets left the output, %0d were expected", pkts_out, pkts_kept);
            abort_run();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== src/p4_proc_core.sv ====
`timescale 1ns/1ps

module p4_proc_core #(
    parameter int DATA_BYTES = 8
) (
    input  logic                                  core_clk,
    input  logic                                  srst,
    input  logic [p4_proc_pkg::TIMESTAMP_WID-1:0] timestamp,

    // ingress stream.
    input  logic                                  in_tvalid,
    output logic                                  in_tready,
    input  logic [DATA_BYTES*8-1:0]               in_tdata,
    input  logic [DATA_BYTES-1:0]                 in_tkeep,
    input  logic                                  in_tlast,
    input  p4_proc_pkg::port_t                    in_tid,

    // towards the P4 block.
    output logic                                  p4_tx_tvalid,
    input  logic                                  p4_tx_tready,
    output logic [DATA_BYTES*8-1:0]               p4_tx_tdata,
    output logic [DATA_BYTES-1:0]                 p4_tx_tkeep,
    output logic                                  p4_tx_tlast,
    output p4_proc_pkg::user_metadata_t           p4_meta_out,
    output logic                                  p4_meta_out_valid,

    // back from the P4 block.
    input  logic                                  p4_rx_tvalid,
    output logic                                  p4_rx_tready,
    input  logic [DATA_BYTES*8-1:0]               p4_rx_tdata,
    input  logic [DATA_BYTES-1:0]                 p4_rx_tkeep,
    input  logic                                  p4_rx_tlast,
    input  p4_proc_pkg::user_metadata_t           p4_meta_in,
    input  logic                                  p4_meta_in_valid,

    // egress stream.
    output logic                                  out_tvalid,
    input  logic                                  out_tready,
    output logic [DATA_BYTES*8-1:0]               out_tdata,
    output logic [DATA_BYTES-1:0]                 out_tkeep,
    output logic                                  out_tlast,
    output p4_proc_pkg::port_t                    out_tid,
    output p4_proc_pkg::port_t                    out_tdest
);

    pkt_stream_if #(.DATA_BYTES(DATA_BYTES)) dec_stream ();
    pkt_stream_if #(.DATA_BYTES(DATA_BYTES)) flt_stream ();

    // ------------------------------------------------------------------------
    // ingress side. packet beats go to the P4 block as they are.
    // ------------------------------------------------------------------------
    assign p4_tx_tvalid = in_tvalid;
    assign p4_tx_tdata  = in_tdata;
    assign p4_tx_tkeep  = in_tkeep;
    assign p4_tx_tlast  = in_tlast;

    p4_meta_encode u_encode (
        .core_clk          (core_clk),
        .srst              (srst),
        .timestamp         (timestamp),
        .in_tvalid         (in_tvalid),
        .in_tready         (in_tready),
        .in_tlast          (in_tlast),
        .in_tid            (in_tid),
        .p4_tx_tready      (p4_tx_tready),
        .p4_meta_out       (p4_meta_out),
        .p4_meta_out_valid (p4_meta_out_valid)
    );

    // ------------------------------------------------------------------------
    // return side. decode, drop, truncate.
    // ------------------------------------------------------------------------
    p4_meta_decode #(.DATA_BYTES(DATA_BYTES)) u_decode (
        .core_clk         (core_clk),
        .srst             (srst),
        .p4_rx_tvalid     (p4_rx_tvalid),
        .p4_rx_tready     (p4_rx_tready),
        .p4_rx_tdata      (p4_rx_tdata),
        .p4_rx_tkeep      (p4_rx_tkeep),
        .p4_rx_tlast      (p4_rx_tlast),
        .p4_meta_in       (p4_meta_in),
        .p4_meta_in_valid (p4_meta_in_valid),
        .dec              (dec_stream.tx)
    );

    pkt_drop_filter #(.DATA_BYTES(DATA_BYTES)) u_drop (
        .core_clk (core_clk),
        .srst     (srst),
        .flt_in   (dec_stream.rx),
        .flt_out  (flt_stream.tx)
    );

    pkt_truncate #(.DATA_BYTES(DATA_BYTES)) u_trunc (
        .core_clk   (core_clk),
        .srst       (srst),
        .trc_in     (flt_stream.rx),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tlast  (out_tlast),
        .out_tid    (out_tid),
        .out_tdest  (out_tdest)
    );

endmodule

// ==== pkt_filter/pkt_truncate.sv ====
`timescale 1ns/1ps

module pkt_truncate #(
    parameter int DATA_BYTES = 8
) (
    input  logic                    core_clk,
    input  logic                    srst,
    pkt_stream_if.rx                trc_in,
    output logic                    out_tvalid,
    input  logic                    out_tready,
    output logic [DATA_BYTES*8-1:0] out_tdata,
    output logic [DATA_BYTES-1:0]   out_tkeep,
    output logic                    out_tlast,
    output p4_proc_pkg::port_t      out_tid,
    output p4_proc_pkg::port_t      out_tdest
);
    import p4_proc_pkg::*;

    // one spare bit so the running end never wraps.
    localparam int CNT_WID = TRUNC_LEN_WID + 1;

    logic [CNT_WID-1:0]    byte_cnt;
    logic [CNT_WID-1:0]    end_cnt;
    logic [DATA_BYTES-1:0] keep_mask;
    logic [DATA_BYTES-1:0] keep_cut;
    logic                  cut;
    logic                  discard;
    logic                  load_ok;
    logic                  in_fire;

    // ------------------------------------------------------------------------
    // byte accounting.
    // ------------------------------------------------------------------------
    assign end_cnt = byte_cnt + CNT_WID'(DATA_BYTES);
    assign cut     = trc_in.trunc.enable && !discard &&
                     (end_cnt >= CNT_WID'(trc_in.trunc.length));

    always_comb begin
        for (int i = 0; i < DATA_BYTES; i++) begin
            keep_mask[i] = (byte_cnt + CNT_WID'(i)) < CNT_WID'(trc_in.trunc.length);
        end
    end

    assign keep_cut = cut ? (trc_in.tkeep & keep_mask) : trc_in.tkeep;

    always_ff @(posedge core_clk) begin
        if (srst) begin
            byte_cnt <= '0;
            discard  <= 1'b0;
        end else if (in_fire) begin
            if (trc_in.tlast) begin
                byte_cnt <= '0;
                discard  <= 1'b0;
            end else begin
                byte_cnt <= end_cnt;
                if (cut) begin
                    discard <= 1'b1;
                end
            end
        end
    end

    // tail beats after the cut drain at full rate.
    assign load_ok       = !out_tvalid || out_tready;
    assign trc_in.tready = load_ok || discard;
    assign in_fire       = trc_in.tvalid && trc_in.tready;

    // ------------------------------------------------------------------------
    // output register.
    // ------------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst) begin
            out_tvalid <= 1'b0;
        end else if (load_ok) begin
            out_tvalid <= trc_in.tvalid && !discard;
        end
    end

    always_ff @(posedge core_clk) begin
        if (load_ok && trc_in.tvalid && !discard) begin
            out_tdata <= trc_in.tdata;
            out_tkeep <= keep_cut;
            out_tlast <= trc_in.tlast || cut;
            out_tid   <= trc_in.tid;
            out_tdest <= trc_in.tdest;
        end
    end

    // a stalled input beat is held until it is taken.
    a_in_stable : assert property (
        @(posedge core_clk) disable iff (srst)
        trc_in.tvalid && !trc_in.tready |=>
            trc_in.tvalid &&
            $stable({trc_in.tdata, trc_in.tkeep, trc_in.tlast, trc_in.tid, trc_in.tdest,
                     trc_in.trunc})
    );

endmodule

// ==== pkt_filter/pkt_drop_filter.sv ====
`timescale 1ns/1ps

module pkt_drop_filter #(
    parameter int DATA_BYTES = 8
) (
    input logic      core_clk,
    input logic      srst,
    pkt_stream_if.rx flt_in,
    pkt_stream_if.tx flt_out
);
    import p4_proc_pkg::*;

    logic                    sop;
    logic                    drop_held;
    logic                    drop_now;
    logic                    load_ok;
    logic                    in_fire;
    logic                    valid_q;
    logic [DATA_BYTES*8-1:0] data_q;
    logic [DATA_BYTES-1:0]   keep_q;
    logic                    last_q;
    port_t                   tid_q;
    port_t                   tdest_q;
    trunc_meta_t             trunc_q;

    // ------------------------------------------------------------------------
    // drop decision, made on the first beat and held to the last.
    // ------------------------------------------------------------------------
    always_comb begin
        if (sop) begin
            drop_now = (flt_in.tdest.typ == UNSET) ||
                       (flt_in.tlast && flt_in.tkeep == '0);
        end else begin
            drop_now = drop_held;
        end
    end

    always_ff @(posedge core_clk) begin
        if (srst) begin
            sop       <= 1'b1;
            drop_held <= 1'b0;
        end else if (in_fire) begin
            sop       <= flt_in.tlast;
            drop_held <= drop_now;
        end
    end

    // dropped beats are swallowed without waiting on the output.
    assign load_ok       = !valid_q || flt_out.tready;
    assign flt_in.tready = load_ok || drop_now;
    assign in_fire       = flt_in.tvalid && flt_in.tready;

    // ------------------------------------------------------------------------
    // output register.
    // ------------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (srst) begin
            valid_q <= 1'b0;
        end else if (load_ok) begin
            valid_q <= flt_in.tvalid && !drop_now;
        end
    end

    always_ff @(posedge core_clk) begin
        if (load_ok && flt_in.tvalid && !drop_now) begin
            data_q  <= flt_in.tdata;
            keep_q  <= flt_in.tkeep;
            last_q  <= flt_in.tlast;
            tid_q   <= flt_in.tid;
            tdest_q <= flt_in.tdest;
            trunc_q <= flt_in.trunc;
        end
    end

    assign flt_out.tvalid = valid_q;
    assign flt_out.tdata  = data_q;
    assign flt_out.tkeep  = keep_q;
    assign flt_out.tlast  = last_q;
    assign flt_out.tid    = tid_q;
    assign flt_out.tdest  = tdest_q;
    assign flt_out.trunc  = trunc_q;

    // an empty beat is only legal as the single beat of a zero-length packet.
    a_keep_nonzero : assert property (
        @(posedge core_clk) disable iff (srst)
        flt_in.tvalid && !flt_in.tlast |-> flt_in.tkeep != '0
    );

endmodule

// ==== p4_meta/p4_meta_decode.sv ====
`timescale 1ns/1ps

module p4_meta_decode #(
    parameter int DATA_BYTES = 8
) (
    input  logic                        core_clk,
    input  logic                        srst,
    input  logic                        p4_rx_tvalid,
    output logic                        p4_rx_tready,
    input  logic [DATA_BYTES*8-1:0]     p4_rx_tdata,
    input  logic [DATA_BYTES-1:0]       p4_rx_tkeep,
    input  logic                        p4_rx_tlast,
    input  p4_proc_pkg::user_metadata_t p4_meta_in,
    input  logic                        p4_meta_in_valid,
    pkt_stream_if.tx                    dec
);
    import p4_proc_pkg::*;

    port_t        held_ingress;
    egress_code_u held_code;
    trunc_meta_t  held_trunc;
    egress_code_u code;
    port_t        dest_port;
    logic         sop;

    // ------------------------------------------------------------------------
    // metadata hold for the later beats of a packet.
    // ------------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (p4_meta_in_valid) begin
            held_ingress  <= p4_meta_in.ingress_port;
            held_code.raw <= p4_meta_in.egress_code.raw;
            held_trunc    <= p4_meta_in.trunc;
        end
    end

    always_ff @(posedge core_clk) begin
        if (srst) begin
            sop <= 1'b1;
        end else if (p4_rx_tvalid && p4_rx_tready) begin
            sop <= p4_rx_tlast;
        end
    end

    // live metadata on the first beat, held copy afterwards.
    assign code.raw = p4_meta_in_valid ? p4_meta_in.egress_code.raw : held_code.raw;

    // ------------------------------------------------------------------------
    // egress code decode table.
    // ------------------------------------------------------------------------
    always_comb begin
        case (code.fields.typ_code)
            3'd0:    dest_port.typ = PHY;
            3'd1:    dest_port.typ = PF;
            3'd2:    dest_port.typ = VF0;
            3'd3:    dest_port.typ = APP_IGR;
            3'd4:    dest_port.typ = VF2;
            // 5, 6 and 7 are all unset.
            default: dest_port.typ = UNSET;
        endcase
        dest_port.num = code.fields.num;
    end

    assign dec.tvalid   = p4_rx_tvalid;
    assign dec.tdata    = p4_rx_tdata;
    assign dec.tkeep    = p4_rx_tkeep;
    assign dec.tlast    = p4_rx_tlast;
    assign dec.tdest    = dest_port;
    assign dec.tid      = p4_meta_in_valid ? p4_meta_in.ingress_port : held_ingress;
    assign dec.trunc    = p4_meta_in_valid ? p4_meta_in.trunc : held_trunc;
    assign p4_rx_tready = dec.tready;

    // the P4 block only strobes metadata alongside a first beat.
    a_meta_on_first_beat : assert property (
        @(posedge core_clk) disable iff (srst)
        p4_meta_in_valid |-> p4_rx_tvalid && sop
    );

endmodule

// ==== p4_meta/p4_meta_encode.sv ====
`timescale 1ns/1ps

module p4_meta_encode (
    input  logic                                    core_clk,
    input  logic                                    srst,
    input  logic [p4_proc_pkg::TIMESTAMP_WID-1:0]   timestamp,
    input  logic                                    in_tvalid,
    output logic                                    in_tready,
    input  logic                                    in_tlast,
    input  p4_proc_pkg::port_t                      in_tid,
    input  logic                                    p4_tx_tready,
    output p4_proc_pkg::user_metadata_t             p4_meta_out,
    output logic                                    p4_meta_out_valid
);
    import p4_proc_pkg::*;

    logic sop;

    // the P4 block sets the pace of the ingress stream.
    assign in_tready = p4_tx_tready;

    // first-beat tracker, set again once a last beat has gone out.
    always_ff @(posedge core_clk) begin
        if (srst) begin
            sop <= 1'b1;
        end else if (in_tvalid && in_tready) begin
            sop <= in_tlast;
        end
    end

    // ------------------------------------------------------------------------
    // outgoing metadata.
    // ------------------------------------------------------------------------
    always_comb begin
        p4_meta_out.timestamp                   = timestamp;
        p4_meta_out.ingress_port                = in_tid;
        // egress defaults to unset, the P4 program must pick a port.
        p4_meta_out.egress_code.fields.typ_code = TYPE_CODE_UNSET_FIRST;
        p4_meta_out.egress_code.fields.num      = in_tid.num;
        p4_meta_out.trunc.enable                = 1'b0;
        p4_meta_out.trunc.length                = '0;
    end

    assign p4_meta_out_valid = in_tvalid && sop;

    // strobe stays up until its beat is taken.
    a_meta_strobe_held : assert property (
        @(posedge core_clk) disable iff (srst)
        p4_meta_out_valid && !p4_tx_tready |=> p4_meta_out_valid
    );

endmodule

// ==== common/pkt_stream_if.sv ====
`timescale 1ns/1ps

interface pkt_stream_if #(
    parameter int DATA_BYTES = 8
) ();
    import p4_proc_pkg::*;

    logic                    tvalid;
    logic                    tready;
    logic [DATA_BYTES*8-1:0] tdata;
    logic [DATA_BYTES-1:0]   tkeep;
    logic                    tlast;
    port_t                   tid;
    port_t                   tdest;
    // truncation request, constant across a packet.
    trunc_meta_t             trunc;

    modport tx (
        output tvalid, tdata, tkeep, tlast, tid, tdest, trunc,
        input  tready
    );

    modport rx (
        input  tvalid, tdata, tkeep, tlast, tid, tdest, trunc,
        output tready
    );

endinterface

// ==== common/p4_proc_pkg.sv ====
package p4_proc_pkg;

    // ------------------------------------------------------------------------
    // widths.
    // ------------------------------------------------------------------------
    localparam int TIMESTAMP_WID = 32;
    localparam int PORT_NUM_WID  = 1;
    localparam int TRUNC_LEN_WID = 16;
    localparam int TYPE_CODE_WID = 3;

    // codes 5 to 7 from the P4 block all decode to UNSET.
    localparam logic [TYPE_CODE_WID-1:0] TYPE_CODE_UNSET_FIRST = 3'd5;

    // ------------------------------------------------------------------------
    // port and metadata types.
    // ------------------------------------------------------------------------
    typedef enum logic [TYPE_CODE_WID-1:0] {
        PHY     = 3'd0,
        PF      = 3'd1,
        VF0     = 3'd2,
        APP_IGR = 3'd3,
        VF2     = 3'd4,
        UNSET   = 3'd5
    } port_typ_t;

    // used as stream tid and tdest.
    typedef struct packed {
        port_typ_t               typ;
        logic [PORT_NUM_WID-1:0] num;
    } port_t;

    typedef struct packed {
        logic [TYPE_CODE_WID-1:0] typ_code;
        logic [PORT_NUM_WID-1:0]  num;
    } egress_fields_t;

    // raw view for moving the code around, field view for decoding.
    typedef union packed {
        logic [TYPE_CODE_WID+PORT_NUM_WID-1:0] raw;
        egress_fields_t                        fields;
    } egress_code_u;

    typedef struct packed {
        logic                     enable;
        logic [TRUNC_LEN_WID-1:0] length;
    } trunc_meta_t;

    typedef struct packed {
        logic [TIMESTAMP_WID-1:0] timestamp;
        port_t                    ingress_port;
        egress_code_u             egress_code;
        trunc_meta_t              trunc;
    } user_metadata_t;

endpackage
